// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_bus_fabric
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_FLAGS ?= +verilator+error+limit+100
PASS_TEXT ?= TB PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BINARY)

# rebuilt only when a source or the file list changes
$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BINARY)
	$(BINARY) $(SIM_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== project.f ====
src/bus_pkg.sv
src/memory_map_pkg.sv
src/wb_priority_arbiter.sv
src/bus_decoder.sv
src/sys_info_regs.sv
src/wb_ram.sv
src/switch_led_port.sv
src/bus_fabric_top.sv
verification/bus_fabric_assert.sv
verification/tb_bus_fabric.sv

// ==== src/bus_decoder.sv ====
`timescale 1ns/1ps

module bus_decoder
    import bus_pkg::*;
    import memory_map_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_reset,
    input  wb_req_t   i_bus_req,

    // per-slave strobes
    output logic      o_info_stb,
    output logic      o_ram_stb,
    output logic      o_swled_stb,

    // per-slave returns
    input  logic      i_info_ack,
    input  logic      i_ram_ack,
    input  logic      i_swled_ack,
    input  bus_data_t i_info_data,
    input  bus_data_t i_ram_data,
    input  bus_data_t i_swled_data,

    output wb_rsp_t   o_bus_rsp
);

    localparam int ADDR_MSB = $bits(word_addr_t) - 1;

    region_t   region;
    logic      info_sel;
    logic      ram_sel;
    logic      swled_sel;
    logic      none_sel;
    logic      req_valid;
    logic      ack_q;
    logic      err_q;
    bus_data_t data_q;

    assign region    = i_bus_req.addr[ADDR_MSB -: REGION_MSB_WIDTH];
    assign req_valid = i_bus_req.cyc && i_bus_req.stb;

    assign ram_sel   = (region == RAM_REGION);
    assign info_sel  = (region == INFO_REGION);
    assign swled_sel = (i_bus_req.addr == SWITCH_LED_ADDR);
    assign none_sel  = !ram_sel && !info_sel && !swled_sel;

    assign o_info_stb  = req_valid && info_sel;
    assign o_ram_stb   = req_valid && ram_sel;
    assign o_swled_stb = req_valid && swled_sel;

    // err one cycle after a strobe that hits no device
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            err_q <= 1'b0;
            ack_q <= 1'b0;
        end else begin
            err_q <= req_valid && none_sel;
            ack_q <= i_info_ack || i_ram_ack || i_swled_ack;
        end
    end

    // info first, then ram, then switch/led
    always_ff @(posedge i_clk) begin
        if (i_info_ack) begin
            data_q <= i_info_data;
        end else if (i_ram_ack) begin
            data_q <= i_ram_data;
        end else if (i_swled_ack) begin
            data_q <= i_swled_data;
        end else begin
            data_q <= '0;
        end
    end

    assign o_bus_rsp.ack   = ack_q;
    // no slave stalls, the arbiter is the only source of stall
    assign o_bus_rsp.stall = 1'b0;
    assign o_bus_rsp.err   = err_q;
    assign o_bus_rsp.data  = data_q;

endmodule

// ==== src/bus_fabric_top.sv ====
`timescale 1ns/1ps

module bus_fabric_top import bus_pkg::*; #(
    parameter int RAM_ADDR_WIDTH = 10
) (
    input  logic    i_clk,
    input  logic    i_reset,

    // processor-side master, wins arbitration
    input  wb_req_t i_cpu_req,
    output wb_rsp_t o_cpu_rsp,

    // debug master
    input  wb_req_t i_dbg_req,
    output wb_rsp_t o_dbg_rsp,

    input  led_t    i_switches,
    output led_t    o_leds,
    output logic    o_irq
);

    wb_req_t   bus_req;
    wb_rsp_t   bus_rsp;
    logic      info_stb;
    logic      ram_stb;
    logic      swled_stb;
    logic      info_ack;
    logic      ram_ack;
    logic      swled_ack;
    bus_data_t info_data;
    bus_data_t ram_data;
    bus_data_t swled_data;

    wb_priority_arbiter arbiter (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_a_req   (i_cpu_req),
        .o_a_rsp   (o_cpu_rsp),
        .i_b_req   (i_dbg_req),
        .o_b_rsp   (o_dbg_rsp),
        .o_bus_req (bus_req),
        .i_bus_rsp (bus_rsp)
    );

    bus_decoder decoder (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_bus_req    (bus_req),
        .o_info_stb   (info_stb),
        .o_ram_stb    (ram_stb),
        .o_swled_stb  (swled_stb),
        .i_info_ack   (info_ack),
        .i_ram_ack    (ram_ack),
        .i_swled_ack  (swled_ack),
        .i_info_data  (info_data),
        .i_ram_data   (ram_data),
        .i_swled_data (swled_data),
        .o_bus_rsp    (bus_rsp)
    );

    // err address is captured from the registered decoder err
    sys_info_regs info (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_stb     (info_stb),
        .i_bus_req (bus_req),
        .i_bus_err (bus_rsp.err),
        .o_ack     (info_ack),
        .o_data    (info_data),
        .o_irq     (o_irq)
    );

    wb_ram #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) ram (
        .i_clk     (i_clk),
        .i_stb     (ram_stb),
        .i_bus_req (bus_req),
        .o_ack     (ram_ack),
        .o_data    (ram_data)
    );

    switch_led_port swled (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_stb      (swled_stb),
        .i_bus_req  (bus_req),
        .o_ack      (swled_ack),
        .o_data     (swled_data),
        .i_switches (i_switches),
        .o_leds     (o_leds)
    );

endmodule

// ==== src/bus_pkg.sv ====
package bus_pkg;

    // lane width inside a bus word
    localparam int BYTE_WIDTH = 8;

    // word address, the two byte-offset bits are not carried
    typedef logic [29:0] word_addr_t;

    typedef logic [31:0] bus_data_t;

    // one enable per byte lane
    typedef logic [3:0] byte_sel_t;

    // board LEDs and switches share this width
    typedef logic [15:0] led_t;

    // signals driven by a bus master
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        word_addr_t addr;
        bus_data_t  data;
        byte_sel_t  sel;
    } wb_req_t;

    // signals returned to a bus master
    typedef struct packed {
        logic      ack;
        logic      stall;
        logic      err;
        bus_data_t data;
    } wb_rsp_t;

endpackage

// ==== src/memory_map_pkg.sv ====
package memory_map_pkg;

    import bus_pkg::*;

    // upper word-address bits that pick one of the large regions
    localparam int REGION_MSB_WIDTH = 9;

    typedef logic [REGION_MSB_WIDTH-1:0] region_t;

    // memory region, word addresses 0x0000000 to 0x01FFFFF
    localparam region_t RAM_REGION = 9'd0;

    // information device occupies the next region
    localparam region_t INFO_REGION = 9'd1;

    // single-word IO devices
    localparam word_addr_t SWITCH_LED_ADDR = 30'h400001;

    // low address bits decoded by the information device
    localparam int INFO_OFFSET_WIDTH = 4;

    typedef enum logic [INFO_OFFSET_WIDTH-1:0] {
        ID          = 4'd0,
        SCRATCH     = 4'd1,
        ERR_ADDR    = 4'd2,
        POWER_COUNT = 4'd3,
        IRQ         = 4'd4
    } info_reg_e;

    // returned by a read of offset ID
    localparam bus_data_t INFO_ID_WORD = 32'h20191028;

endpackage

// ==== src/switch_led_port.sv ====
`timescale 1ns/1ps

module switch_led_port import bus_pkg::*; (
    input  logic      i_clk,
    input  logic      i_reset,
    input  logic      i_stb,
    input  wb_req_t   i_bus_req,
    output logic      o_ack,
    output bus_data_t o_data,
    input  led_t      i_switches,
    output led_t      o_leds
);

    // lanes 0 and 1 each enable one LED byte
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_leds <= '0;
        end else if (i_stb && i_bus_req.we) begin
            if (i_bus_req.sel[0]) begin
                o_leds[BYTE_WIDTH-1:0] <= i_bus_req.data[BYTE_WIDTH-1:0];
            end
            if (i_bus_req.sel[1]) begin
                o_leds[2*BYTE_WIDTH-1:BYTE_WIDTH] <= i_bus_req.data[2*BYTE_WIDTH-1:BYTE_WIDTH];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= i_stb;
        end
    end

    // switches in the upper half, LEDs in the lower
    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            o_data <= {i_switches, o_leds};
        end
    end

endmodule

// ==== src/sys_info_regs.sv ====
`timescale 1ns/1ps

module sys_info_regs
    import bus_pkg::*;
    import memory_map_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_reset,
    input  logic      i_stb,
    input  wb_req_t   i_bus_req,
    input  logic      i_bus_err,
    output logic      o_ack,
    output bus_data_t o_data,
    output logic      o_irq
);

    info_reg_e  offset;
    bus_data_t  scratch;
    bus_data_t  power_count;
    word_addr_t prev_addr;
    word_addr_t err_addr;

    assign offset = info_reg_e'(i_bus_req.addr[INFO_OFFSET_WIDTH-1:0]);

    // register writes
    always_ff @(posedge i_clk) begin
        if (i_stb && i_bus_req.we && offset == SCRATCH) begin
            scratch <= i_bus_req.data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_irq <= 1'b0;
        end else if (i_stb && i_bus_req.we && offset == IRQ) begin
            o_irq <= i_bus_req.data[0];
        end
    end

    // err arrives a cycle after its strobe, so keep the address one cycle
    always_ff @(posedge i_clk) begin
        prev_addr <= i_bus_req.addr;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            err_addr <= '0;
        end else if (i_bus_err) begin
            err_addr <= prev_addr;
        end
    end

    // cycles since reset, top bit sticks once set
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            power_count <= '0;
        end else if (!power_count[31]) begin
            power_count <= power_count + 1'b1;
        end else begin
            power_count[30:0] <= power_count[30:0] + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= i_stb;
        end
    end

    // read mux by offset
    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            case (offset)
                ID:          o_data <= INFO_ID_WORD;
                SCRATCH:     o_data <= scratch;
                ERR_ADDR:    o_data <= {err_addr, 2'b00};
                POWER_COUNT: o_data <= power_count;
                IRQ:         o_data <= {31'h0, o_irq};
                default:     o_data <= '0;
            endcase
        end
    end

endmodule

// ==== src/wb_priority_arbiter.sv ====
`timescale 1ns/1ps

module wb_priority_arbiter import bus_pkg::*; (
    input  logic    i_clk,
    input  logic    i_reset,

    // master a, has priority
    input  wb_req_t i_a_req,
    output wb_rsp_t o_a_rsp,

    // master b
    input  wb_req_t i_b_req,
    output wb_rsp_t o_b_rsp,

    // shared bus
    output wb_req_t o_bus_req,
    input  wb_rsp_t i_bus_rsp
);

    // set while master b owns the bus
    logic    b_owner;
    wb_rsp_t stalled_rsp;

    // ownership rests on a
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            b_owner <= 1'b0;
        end else if (b_owner) begin
            // b keeps the bus for as long as it holds cyc
            b_owner <= i_b_req.cyc;
        end else begin
            // only take over when a is idle, so none of a's strobes are in flight
            b_owner <= i_b_req.cyc && !i_a_req.cyc;
        end
    end

    assign o_bus_req = b_owner ? i_b_req : i_a_req;

    // what the waiting master sees
    always_comb begin
        stalled_rsp       = i_bus_rsp;
        stalled_rsp.ack   = 1'b0;
        stalled_rsp.err   = 1'b0;
        stalled_rsp.stall = 1'b1;
    end

    // read data reaches both masters, handshake only the owner
    assign o_a_rsp = b_owner ? stalled_rsp : i_bus_rsp;
    assign o_b_rsp = b_owner ? i_bus_rsp : stalled_rsp;

endmodule

// ==== src/wb_ram.sv ====
`timescale 1ns/1ps

module wb_ram import bus_pkg::*; #(
    parameter int RAM_ADDR_WIDTH = 10
) (
    input  logic      i_clk,
    input  logic      i_stb,
    input  wb_req_t   i_bus_req,
    output logic      o_ack,
    output bus_data_t o_data
);

    localparam int RAM_DEPTH = 2 ** RAM_ADDR_WIDTH;
    localparam int LANES     = $bits(byte_sel_t);

    bus_data_t                 mem [RAM_DEPTH];
    logic [RAM_ADDR_WIDTH-1:0] ram_idx;

    // upper address bits ignored, the region wraps over the depth
    assign ram_idx = i_bus_req.addr[RAM_ADDR_WIDTH-1:0];

    // byte-lane writes
    always_ff @(posedge i_clk) begin
        if (i_stb && i_bus_req.we) begin
            for (int lane = 0; lane < LANES; lane++) begin
                if (i_bus_req.sel[lane]) begin
                    mem[ram_idx][lane*BYTE_WIDTH +: BYTE_WIDTH] <=
                        i_bus_req.data[lane*BYTE_WIDTH +: BYTE_WIDTH];
                end
            end
        end
    end

    // read word and ack one cycle after the strobe
    always_ff @(posedge i_clk) begin
        o_ack <= i_stb;
        if (i_stb) begin
            o_data <= mem[ram_idx];
        end
    end

endmodule

// ==== verification/bus_fabric_assert.sv ====
`timescale 1ns/1ps

module bus_fabric_assert
    import bus_pkg::*;
    import memory_map_pkg::*;
(
    input logic    i_clk,
    input logic    i_reset,
    input wb_req_t i_cpu_req,
    input wb_req_t i_dbg_req,
    input wb_rsp_t i_cpu_rsp,
    input wb_rsp_t i_dbg_rsp,
    input wb_req_t i_bus_req,
    input wb_rsp_t i_bus_rsp,
    input led_t    i_leds,
    input logic    i_irq
);

    localparam int REGION_SHIFT = $bits(word_addr_t) - REGION_MSB_WIDTH;

    // count of failed assertions
    int      fail_count = 0;
    region_t region;
    logic    mapped;
    logic    accept;
    logic    dbg_owner;

    assign region = region_t'(i_bus_req.addr >> REGION_SHIFT);
    assign mapped = (region == RAM_REGION) || (region == INFO_REGION)
                    || (i_bus_req.addr == SWITCH_LED_ADDR);
    assign accept = i_bus_req.cyc && i_bus_req.stb && !i_bus_rsp.stall;

    // bus owner rebuilt from the masters' cyc lines
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            dbg_owner <= 1'b0;
        end else if (dbg_owner) begin
            dbg_owner <= i_dbg_req.cyc;
        end else begin
            dbg_owner <= i_dbg_req.cyc && !i_cpu_req.cyc;
        end
    end

    ack_err_exclusive: assert property (@(posedge i_clk)
        !(i_cpu_rsp.ack && i_cpu_rsp.err) && !(i_dbg_rsp.ack && i_dbg_rsp.err))
    else begin
        $error("ack and err high together on a master");
        fail_count++;
    end

    // the master without the bus sees stall and no ack
    waiting_no_ack: assert property (@(posedge i_clk) disable iff (i_reset)
        dbg_owner ? (i_cpu_rsp.stall && !i_cpu_rsp.ack)
                  : (i_dbg_rsp.stall && !i_dbg_rsp.ack))
    else begin
        $error("master without the bus saw ack or was not stalled");
        fail_count++;
    end

    mapped_ack: assert property (@(posedge i_clk) disable iff (i_reset)
        $past(accept && mapped, 2) |-> i_bus_rsp.ack && !i_bus_rsp.err)
    else begin
        $error("mapped strobe not acked two cycles after acceptance");
        fail_count++;
    end

    ack_origin: assert property (@(posedge i_clk) disable iff (i_reset)
        i_bus_rsp.ack |-> $past(accept && mapped, 2))
    else begin
        $error("ack without a mapped strobe two cycles earlier");
        fail_count++;
    end

    unmapped_err: assert property (@(posedge i_clk) disable iff (i_reset)
        $past(accept && !mapped) |-> i_bus_rsp.err && !i_bus_rsp.ack)
    else begin
        $error("unmapped strobe not answered by err one cycle later");
        fail_count++;
    end

    err_origin: assert property (@(posedge i_clk) disable iff (i_reset)
        i_bus_rsp.err |-> $past(accept && !mapped))
    else begin
        $error("err without an unmapped strobe one cycle earlier");
        fail_count++;
    end

    reset_values: assert property (@(posedge i_clk)
        ($past(i_reset) && !i_reset) |-> (i_leds == '0) && !i_irq)
    else begin
        $error("leds or irq not cleared by reset");
        fail_count++;
    end

endmodule

bind bus_fabric_top bus_fabric_assert protocol_checks (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_cpu_req (i_cpu_req),
    .i_dbg_req (i_dbg_req),
    .i_cpu_rsp (o_cpu_rsp),
    .i_dbg_rsp (o_dbg_rsp),
    .i_bus_req (bus_req),
    .i_bus_rsp (bus_rsp),
    .i_leds    (o_leds),
    .i_irq     (o_irq)
);

// ==== verification/tb_bus_fabric.sv ====
`timescale 1ns/1ps

module tb_bus_fabric
    import bus_pkg::*;
    import memory_map_pkg::*;
();

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 16;
    localparam int RAM_ADDR_WIDTH = 10;
    localparam int RAM_DEPTH      = 1 << RAM_ADDR_WIDTH;
    localparam int RAM_WORDS      = 8;
    localparam int WAIT_LIMIT     = 40;
    // ram 3 passes, info 5, unmapped 2, power 2, arbitration 2, switch/led 3
    localparam int TXN_COUNT       = 3 * RAM_WORDS + 14;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 40 * TXN_COUNT;

    localparam word_addr_t RAM_REGION_MASK = 30'h01FFFFF;
    localparam word_addr_t INFO_BASE       = 30'h0200000;
    localparam word_addr_t UNMAPPED_ADDR   = 30'h0812345;

    logic        clk;
    logic        reset;
    wb_req_t     cpu_req;
    wb_req_t     dbg_req;
    wb_rsp_t     cpu_rsp;
    wb_rsp_t     dbg_rsp;
    led_t        switches;
    led_t        leds;
    logic        irq;
    int          checks;
    int          fails;
    int          cycle_count;
    logic [31:0] rng_state = 32'd67;
    bus_data_t   ram_model [int];
    word_addr_t  ram_addrs [RAM_WORDS];

    bus_fabric_top #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) dut (
        .i_clk      (clk),
        .i_reset    (reset),
        .i_cpu_req  (cpu_req),
        .o_cpu_rsp  (cpu_rsp),
        .i_dbg_req  (dbg_req),
        .o_dbg_rsp  (dbg_rsp),
        .i_switches (switches),
        .o_leds     (leds),
        .o_irq      (irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset) begin
            cycle_count <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function bus_data_t rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // only the enabled lanes take the new byte
    function automatic bus_data_t merge_bytes(input bus_data_t old_word,
                                              input bus_data_t new_word,
                                              input byte_sel_t sel);
        bus_data_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    function automatic int ram_index(input word_addr_t addr);
        return int'(addr % RAM_DEPTH);
    endfunction

    function automatic word_addr_t info_addr(input info_reg_e reg_off);
        return INFO_BASE + word_addr_t'(reg_off);
    endfunction

    task automatic check_value(input string sig, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            fails++;
            $display("CHECK FAILED at %0t: %s expected 0x%08h, got 0x%08h",
                     $time, sig, exp, act);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            fails++;
            $display("%0t: %s", $time, what);
        end
    endtask

    task automatic drive_req(input bit use_dbg, input wb_req_t req);
        if (use_dbg) begin
            dbg_req <= req;
        end else begin
            cpu_req <= req;
        end
    endtask

    // one strobe, held until not stalled, then cyc held until ack or err
    task automatic bus_xfer(input bit use_dbg, input bit write, input word_addr_t addr,
                            input bus_data_t wdata, input byte_sel_t sel,
                            output wb_rsp_t rsp, output int stall_cycles);
        wb_req_t req;
        int      waited;
        req = '{cyc: 1'b1, stb: 1'b1, we: write, addr: addr, data: wdata, sel: sel};
        stall_cycles = 0;
        waited = 0;
        @(posedge clk);
        drive_req(use_dbg, req);
        do begin
            @(negedge clk);
            rsp = use_dbg ? dbg_rsp : cpu_rsp;
            if (rsp.stall) begin
                stall_cycles++;
            end
        end while (rsp.stall && stall_cycles < WAIT_LIMIT);
        check_true(!rsp.stall, "master stayed stalled, request never accepted");
        @(posedge clk);
        req.stb = 1'b0;
        drive_req(use_dbg, req);
        do begin
            @(negedge clk);
            rsp = use_dbg ? dbg_rsp : cpu_rsp;
            waited++;
        end while (!rsp.ack && !rsp.err && waited < WAIT_LIMIT);
        check_true(rsp.ack || rsp.err, "no ack or err after an accepted strobe");
        @(posedge clk);
        drive_req(use_dbg, '0);
    endtask

    task automatic write_word(input bit use_dbg, input word_addr_t addr,
                              input bus_data_t data, input byte_sel_t sel);
        wb_rsp_t rsp;
        int      stalls;
        bus_xfer(use_dbg, 1'b1, addr, data, sel, rsp, stalls);
        check_value(use_dbg ? "dbg_rsp.err" : "cpu_rsp.err", 32'd0, 32'(rsp.err));
    endtask

    task automatic read_word(input bit use_dbg, input word_addr_t addr,
                             output bus_data_t data);
        wb_rsp_t rsp;
        int      stalls;
        bus_xfer(use_dbg, 1'b0, addr, '0, 4'hF, rsp, stalls);
        check_value(use_dbg ? "dbg_rsp.err" : "cpu_rsp.err", 32'd0, 32'(rsp.err));
        data = rsp.data;
    endtask

    task automatic finish_test(input string name, input int fails_before);
        if (fails == fails_before) begin
            $display("test %-12s ok", name);
        end else begin
            $display("test %-12s failed, %0d mismatches", name, fails - fails_before);
        end
    endtask

    initial begin
        bus_data_t rd;
        bus_data_t rd2;
        bus_data_t wd;
        byte_sel_t sel;
        wb_rsp_t   cpu_seen;
        wb_rsp_t   dbg_seen;
        int        cpu_stalls;
        int        dbg_stalls;
        int        mark;
        int        total;
        led_t      leds_exp;

        reset = 1'b1;
        cpu_req = '0;
        dbg_req = '0;
        switches = '0;
        checks = 0;
        fails = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);

        // full words first so every later read is defined
        mark = fails;
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram_addrs[i] = word_addr_t'(rand_word()) & RAM_REGION_MASK;
            wd = rand_word();
            write_word(i[0], ram_addrs[i], wd, 4'hF);
            ram_model[ram_index(ram_addrs[i])] = wd;
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            wd = rand_word();
            sel = byte_sel_t'(rand_word());
            write_word(!i[0], ram_addrs[i], wd, sel);
            ram_model[ram_index(ram_addrs[i])] =
                merge_bytes(ram_model[ram_index(ram_addrs[i])], wd, sel);
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            read_word(i[1], ram_addrs[i], rd);
            check_value(i[1] ? "dbg_rsp.data" : "cpu_rsp.data",
                        ram_model[ram_index(ram_addrs[i])], rd);
        end
        finish_test("ram", mark);

        mark = fails;
        read_word(1'b0, info_addr(ID), rd);
        check_value("cpu_rsp.data", 32'h20191028, rd);
        wd = rand_word();
        write_word(1'b1, info_addr(SCRATCH), wd, 4'hF);
        read_word(1'b0, info_addr(SCRATCH), rd);
        check_value("cpu_rsp.data", wd, rd);
        write_word(1'b0, info_addr(IRQ), 32'd1, 4'hF);
        check_value("o_irq", 32'd1, 32'(irq));
        write_word(1'b1, info_addr(IRQ), 32'd0, 4'hF);
        check_value("o_irq", 32'd0, 32'(irq));
        finish_test("info", mark);

        mark = fails;
        bus_xfer(1'b1, 1'b0, UNMAPPED_ADDR, '0, 4'hF, dbg_seen, dbg_stalls);
        check_value("dbg_rsp.err", 32'd1, 32'(dbg_seen.err));
        check_value("dbg_rsp.ack", 32'd0, 32'(dbg_seen.ack));
        read_word(1'b0, info_addr(ERR_ADDR), rd);
        check_value("cpu_rsp.data", bus_data_t'(UNMAPPED_ADDR) * 4, rd);
        finish_test("unmapped", mark);

        mark = fails;
        read_word(1'b0, info_addr(POWER_COUNT), rd);
        repeat (20) @(posedge clk);
        read_word(1'b1, info_addr(POWER_COUNT), rd2);
        check_true(rd2 > rd, "power count did not increase between reads");
        check_true(rd < bus_data_t'(cycle_count), "first power count not below cycle count");
        check_true(rd2 < bus_data_t'(cycle_count), "second power count not below cycle count");
        finish_test("power", mark);

        // both masters raise cyc on the same edge, cpu writes first
        mark = fails;
        wd = rand_word();
        fork
            bus_xfer(1'b0, 1'b1, ram_addrs[0], wd, 4'hF, cpu_seen, cpu_stalls);
            bus_xfer(1'b1, 1'b0, ram_addrs[0], '0, 4'hF, dbg_seen, dbg_stalls);
        join
        ram_model[ram_index(ram_addrs[0])] = wd;
        check_true(cpu_stalls == 0, "cpu was stalled although it has priority");
        check_true(dbg_stalls > 0, "dbg was not stalled while cpu held the bus");
        check_value("dbg_rsp.data", wd, dbg_seen.data);
        finish_test("arbitration", mark);

        mark = fails;
        @(posedge clk);
        switches <= led_t'(rand_word());
        wd = rand_word();
        write_word(1'b0, SWITCH_LED_ADDR, wd, 4'b0011);
        leds_exp = wd[15:0];
        check_value("o_leds", 32'(leds_exp), 32'(leds));
        wd = rand_word();
        write_word(1'b1, SWITCH_LED_ADDR, wd, 4'b0010);
        leds_exp[15:8] = wd[15:8];
        check_value("o_leds", 32'(leds_exp), 32'(leds));
        read_word(1'b0, SWITCH_LED_ADDR, rd);
        check_value("cpu_rsp.data", {switches, leds_exp}, rd);
        finish_test("switch_led", mark);

        total = fails + dut.protocol_checks.fail_count;
        $display("checks %0d, mismatches %0d, assertion failures %0d",
                 checks, fails, dut.protocol_checks.fail_count);
        if (total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
